// File: hdl/cpuPkg.sv
`default_nettype none

package cpuPkg;

	typedef logic [31:0] dataWord;
	typedef logic [31:0] instrWord;
	typedef logic [4:0] regIndex;
	typedef logic [5:0] opcode;
	typedef logic [5:0] funcCode;
	typedef logic [7:0] creditCount;

	// Major opcodes, bits 31:26
	localparam opcode opRType = 6'b000000;
	localparam opcode opLi = 6'b001001;
	localparam opcode opXori = 6'b001110;
	localparam opcode opLw = 6'b100011;
	localparam opcode opSw = 6'b101011;

	// R-type function field, bits 5:0
	localparam funcCode funcAdd = 6'b100000;
	localparam funcCode funcSub = 6'b100010;
	localparam funcCode funcSlt = 6'b101010;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		// Unsigned compare, result is 1 or 0
		aluSlt,
		aluXor,
		// Second operand straight through, for LI
		aluPass
	} aluOp;

	typedef enum logic [1:0] {
		kindAlu,
		kindLoad,
		kindStore
	} retireKind;

endpackage

`default_nettype wire

// File: hdl/instrQueue.sv
`timescale 1ns/1ps
`default_nettype none

module instrQueue #(
	parameter int queueDepth = 4
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic instrValid,
	input wire cpuPkg::instrWord instr,
	input wire logic queuePop,
	output logic queueValid,
	output cpuPkg::instrWord queueWord,
	output logic instrCredit
);

	localparam int ptrBits = (queueDepth > 1) ? $clog2(queueDepth) : 1;
	localparam int countBits = $clog2(queueDepth + 1);

	cpuPkg::instrWord entries [queueDepth];
	logic [ptrBits-1:0] writePtr;
	logic [ptrBits-1:0] readPtr;
	logic [countBits-1:0] count;
	logic doPop;
	logic full;

	assign queueValid = count != '0;
	assign queueWord = entries[readPtr];
	assign doPop = queuePop && queueValid;
	assign full = count == countBits'(queueDepth);

	always_ff @(posedge clk) begin
		if (instrValid) begin
			entries[writePtr] <= instr;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			writePtr <= '0;
			readPtr <= '0;
			count <= '0;
			instrCredit <= 1'b0;
		end else begin
			if (instrValid) begin
				writePtr <= (writePtr == ptrBits'(queueDepth - 1)) ? '0 : writePtr + 1'b1;
			end
			if (doPop) begin
				readPtr <= (readPtr == ptrBits'(queueDepth - 1)) ? '0 : readPtr + 1'b1;
			end
			count <= count + countBits'(instrValid) - countBits'(doPop);
			// One credit back per word taken
			instrCredit <= doPop;
		end
	end

	// Sender must hold a credit for every beat
	noPushWhenFull: assert property (@(posedge clk) disable iff (reset) instrValid |-> !full);

endmodule

`default_nettype wire

// File: hdl/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
	input wire logic clk,
	input wire cpuPkg::regIndex readIndexA,
	input wire cpuPkg::regIndex readIndexB,
	input wire logic regWrite,
	input wire cpuPkg::regIndex regWriteIndex,
	input wire cpuPkg::dataWord regWriteData,
	output cpuPkg::dataWord readDataA,
	output cpuPkg::dataWord readDataB
);

	cpuPkg::dataWord regs [32];
	logic writeEnable;

	initial begin
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
	end

	assign writeEnable = regWrite && (regWriteIndex != '0);

	always_ff @(posedge clk) begin
		if (writeEnable) begin
			regs[regWriteIndex] <= regWriteData;
		end
	end

	// Writes in flight show up on the read ports this cycle
	assign readDataA = (readIndexA == '0) ? '0 :
		(writeEnable && regWriteIndex == readIndexA) ? regWriteData : regs[readIndexA];
	assign readDataB = (readIndexB == '0) ? '0 :
		(writeEnable && regWriteIndex == readIndexB) ? regWriteData : regs[readIndexB];

endmodule

`default_nettype wire

// File: hdl/issueStage.sv
`timescale 1ns/1ps
`default_nettype none

module issueStage (
	input wire logic clk,
	input wire logic reset,
	input wire logic queueValid,
	input wire cpuPkg::instrWord queueWord,
	input wire logic retireReady,
	input wire cpuPkg::dataWord readDataA,
	input wire cpuPkg::dataWord readDataB,
	input wire logic regWrite,
	input wire cpuPkg::regIndex regWriteIndex,
	output logic queuePop,
	output cpuPkg::regIndex readIndexA,
	output cpuPkg::regIndex readIndexB,
	output logic issueFire,
	output logic aluIssue,
	output cpuPkg::aluOp aluOperation,
	output logic memIssue,
	output logic memWrite,
	output cpuPkg::dataWord operandA,
	output cpuPkg::dataWord operandB,
	output cpuPkg::dataWord storeData,
	output cpuPkg::regIndex issueDest
);

	cpuPkg::opcode op;
	cpuPkg::funcCode func;
	cpuPkg::regIndex rs;
	cpuPkg::regIndex rt;
	cpuPkg::regIndex rd;
	cpuPkg::regIndex dest;
	cpuPkg::dataWord immExt;
	cpuPkg::aluOp decodedOp;
	logic isRType;
	logic isMem;
	logic isStore;
	logic usesA;
	logic usesB;
	logic hazard;
	logic [31:0] busy;
	logic [31:0] liveBusy;
	logic [31:0] clearMask;
	logic [31:0] setMask;

	assign op = queueWord[31:26];
	assign rs = queueWord[25:21];
	assign rt = queueWord[20:16];
	assign rd = queueWord[15:11];
	assign func = queueWord[5:0];
	assign immExt = {{16{queueWord[15]}}, queueWord[15:0]};

	assign isRType = op == cpuPkg::opRType;
	assign isStore = op == cpuPkg::opSw;
	assign isMem = isStore || (op == cpuPkg::opLw);
	assign usesA = op != cpuPkg::opLi;
	assign usesB = isRType || isStore;
	assign dest = isRType ? rd : (isStore ? '0 : rt);

	assign readIndexA = rs;
	assign readIndexB = rt;

	always_comb begin
		decodedOp = cpuPkg::aluAdd;
		if (op == cpuPkg::opXori) begin
			decodedOp = cpuPkg::aluXor;
		end else if (op == cpuPkg::opLi) begin
			decodedOp = cpuPkg::aluPass;
		end else if (isRType) begin
			case (func)
				cpuPkg::funcSub: decodedOp = cpuPkg::aluSub;
				cpuPkg::funcSlt: decodedOp = cpuPkg::aluSlt;
				default: decodedOp = cpuPkg::aluAdd;
			endcase
		end
	end

	// A retiring write releases its register in the same cycle
	assign clearMask = regWrite ? (32'd1 << regWriteIndex) : '0;
	assign liveBusy = busy & ~clearMask;
	assign hazard = (usesA && liveBusy[rs]) || (usesB && liveBusy[rt]) || liveBusy[dest];

	assign issueFire = queueValid && retireReady && !hazard;
	assign queuePop = issueFire;
	assign setMask = (issueFire && dest != '0) ? (32'd1 << dest) : '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= '0;
			aluIssue <= 1'b0;
			memIssue <= 1'b0;
		end else begin
			busy <= liveBusy | setMask;
			aluIssue <= issueFire && !isMem;
			memIssue <= issueFire && isMem;
		end
	end

	always_ff @(posedge clk) begin
		aluOperation <= decodedOp;
		memWrite <= isStore;
		operandA <= readDataA;
		operandB <= isRType ? readDataB : immExt;
		storeData <= readDataB;
		issueDest <= dest;
	end

endmodule

`default_nettype wire

// File: hdl/aluPipe.sv
`timescale 1ns/1ps
`default_nettype none

module aluPipe (
	input wire logic clk,
	input wire logic reset,
	input wire logic aluIssue,
	input wire cpuPkg::aluOp aluOperation,
	input wire cpuPkg::dataWord operandA,
	input wire cpuPkg::dataWord operandB,
	input wire cpuPkg::regIndex issueDest,
	output logic aluDone,
	output cpuPkg::regIndex aluDest,
	output cpuPkg::dataWord aluResult
);

	cpuPkg::dataWord result;
	cpuPkg::dataWord stageResult;
	cpuPkg::regIndex stageDest;
	logic stageValid;

	always_comb begin
		case (aluOperation)
			cpuPkg::aluSub: result = operandA - operandB;
			cpuPkg::aluSlt: result = (operandA < operandB) ? 32'd1 : 32'd0;
			cpuPkg::aluXor: result = operandA ^ operandB;
			cpuPkg::aluPass: result = operandB;
			default: result = operandA + operandB;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			stageValid <= 1'b0;
			aluDone <= 1'b0;
		end else begin
			stageValid <= aluIssue;
			aluDone <= stageValid;
		end
	end

	// Second stage only delays, to line up with the memory pipe
	always_ff @(posedge clk) begin
		stageResult <= result;
		stageDest <= issueDest;
		aluResult <= stageResult;
		aluDest <= stageDest;
	end

endmodule

`default_nettype wire

// File: hdl/loadStorePipe.sv
`timescale 1ns/1ps
`default_nettype none

module loadStorePipe #(
	parameter int memWords = 16
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic memIssue,
	input wire logic memWrite,
	input wire cpuPkg::dataWord operandA,
	input wire cpuPkg::dataWord operandB,
	input wire cpuPkg::dataWord storeData,
	input wire cpuPkg::regIndex issueDest,
	output logic memDone,
	output cpuPkg::retireKind memKind,
	output cpuPkg::regIndex memDest,
	output cpuPkg::dataWord memResult
);

	localparam int addrBits = (memWords > 1) ? $clog2(memWords) : 1;

	cpuPkg::dataWord dataMem [memWords];
	cpuPkg::dataWord sum;
	cpuPkg::dataWord stageData;
	cpuPkg::regIndex stageDest;
	logic [addrBits-1:0] stageAddr;
	logic stageWrite;
	logic stageValid;

	// Word address wraps at the memory size
	assign sum = operandA + operandB;

	always_ff @(posedge clk) begin
		if (reset) begin
			stageValid <= 1'b0;
			memDone <= 1'b0;
		end else begin
			stageValid <= memIssue;
			memDone <= stageValid;
		end
	end

	always_ff @(posedge clk) begin
		stageAddr <= sum[addrBits-1:0];
		stageWrite <= memWrite;
		stageData <= storeData;
		stageDest <= issueDest;
		if (stageValid && stageWrite) begin
			dataMem[stageAddr] <= stageData;
		end
		if (stageWrite) begin
			memKind <= cpuPkg::kindStore;
			memDest <= '0;
			memResult <= stageData;
		end else begin
			memKind <= cpuPkg::kindLoad;
			memDest <= stageDest;
			memResult <= dataMem[stageAddr];
		end
	end

endmodule

`default_nettype wire

// File: hdl/retireStage.sv
`timescale 1ns/1ps
`default_nettype none

module retireStage (
	input wire logic clk,
	input wire logic reset,
	input wire logic issueFire,
	input wire logic aluDone,
	input wire cpuPkg::regIndex aluDest,
	input wire cpuPkg::dataWord aluResult,
	input wire logic memDone,
	input wire cpuPkg::retireKind memKind,
	input wire cpuPkg::regIndex memDest,
	input wire cpuPkg::dataWord memResult,
	input wire logic retireCredit,
	output logic retireReady,
	output logic regWrite,
	output cpuPkg::regIndex regWriteIndex,
	output cpuPkg::dataWord regWriteData,
	output logic retireValid,
	output cpuPkg::retireKind retireKind,
	output cpuPkg::regIndex retireDest,
	output cpuPkg::dataWord retireValue
);

	// Credits not yet promised to an issued instruction
	cpuPkg::creditCount availCredits;
	// Credits granted and not yet spent on a record
	cpuPkg::creditCount heldCredits;

	assign retireReady = availCredits != '0;
	assign regWriteIndex = retireDest;
	assign regWriteData = retireValue;

	always_ff @(posedge clk) begin
		if (reset) begin
			retireValid <= 1'b0;
			regWrite <= 1'b0;
			availCredits <= '0;
			heldCredits <= '0;
		end else begin
			retireValid <= aluDone || memDone;
			regWrite <= aluDone || (memDone && memKind == cpuPkg::kindLoad);
			availCredits <= availCredits + cpuPkg::creditCount'(retireCredit)
				- cpuPkg::creditCount'(issueFire);
			heldCredits <= heldCredits + cpuPkg::creditCount'(retireCredit)
				- cpuPkg::creditCount'(retireValid);
		end
	end

	always_ff @(posedge clk) begin
		if (aluDone) begin
			retireKind <= cpuPkg::kindAlu;
			retireDest <= aluDest;
			retireValue <= aluResult;
		end else begin
			retireKind <= memKind;
			retireDest <= memDest;
			retireValue <= memResult;
		end
	end

	// Equal pipe depths keep completions one per cycle
	singleDone: assert property (@(posedge clk) disable iff (reset) !(aluDone && memDone));

	// Reservation at issue must leave a credit for every record
	creditHeld: assert property (@(posedge clk) disable iff (reset)
		retireValid |-> heldCredits != '0);

endmodule

`default_nettype wire

// File: hdl/pipelinedCpu.sv
`timescale 1ns/1ps
`default_nettype none

module pipelinedCpu #(
	parameter int queueDepth = 4,
	parameter int memWords = 16
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic instrValid,
	input wire cpuPkg::instrWord instr,
	input wire logic retireCredit,
	output logic instrCredit,
	output logic retireValid,
	output cpuPkg::retireKind retireKind,
	output cpuPkg::regIndex retireDest,
	output cpuPkg::dataWord retireValue
);

	logic queueValid;
	logic queuePop;
	cpuPkg::instrWord queueWord;
	cpuPkg::regIndex readIndexA;
	cpuPkg::regIndex readIndexB;
	cpuPkg::dataWord readDataA;
	cpuPkg::dataWord readDataB;
	logic regWrite;
	cpuPkg::regIndex regWriteIndex;
	cpuPkg::dataWord regWriteData;
	logic retireReady;
	logic issueFire;
	logic aluIssue;
	cpuPkg::aluOp aluOperation;
	logic memIssue;
	logic memWrite;
	cpuPkg::dataWord operandA;
	cpuPkg::dataWord operandB;
	cpuPkg::dataWord storeData;
	cpuPkg::regIndex issueDest;
	logic aluDone;
	cpuPkg::regIndex aluDest;
	cpuPkg::dataWord aluResult;
	logic memDone;
	cpuPkg::retireKind memKind;
	cpuPkg::regIndex memDest;
	cpuPkg::dataWord memResult;

	instrQueue #(.queueDepth(queueDepth)) queue (
		.clk, .reset, .instrValid, .instr, .queuePop,
		.queueValid, .queueWord, .instrCredit
	);

	registerFile regs (
		.clk, .readIndexA, .readIndexB, .regWrite, .regWriteIndex, .regWriteData,
		.readDataA, .readDataB
	);

	issueStage issue (
		.clk, .reset, .queueValid, .queueWord, .retireReady, .readDataA, .readDataB,
		.regWrite, .regWriteIndex, .queuePop, .readIndexA, .readIndexB, .issueFire,
		.aluIssue, .aluOperation, .memIssue, .memWrite, .operandA, .operandB,
		.storeData, .issueDest
	);

	aluPipe alu (
		.clk, .reset, .aluIssue, .aluOperation, .operandA, .operandB, .issueDest,
		.aluDone, .aluDest, .aluResult
	);

	loadStorePipe #(.memWords(memWords)) loadStore (
		.clk, .reset, .memIssue, .memWrite, .operandA, .operandB, .storeData, .issueDest,
		.memDone, .memKind, .memDest, .memResult
	);

	retireStage retire (
		.clk, .reset, .issueFire, .aluDone, .aluDest, .aluResult, .memDone, .memKind,
		.memDest, .memResult, .retireCredit, .retireReady, .regWrite, .regWriteIndex,
		.regWriteData, .retireValid, .retireKind, .retireDest, .retireValue
	);

endmodule

`default_nettype wire

// File: bench/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
	parameter int halfPeriod = 5,
	parameter int resetCycles = 5
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(halfPeriod) clk = ~clk;
	end

	// Release just after an edge, like the other inputs
	initial begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clk);
		#1;
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// File: bench/pipelinedCpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module pipelinedCpuTb;

	localparam int queueDepth = 4;
	localparam int memWords = 16;
	localparam int randomCount = 200;
	// Setup stores come first with two instructions per memory word
	localparam int instrCount = 2 * memWords + randomCount;
	localparam int cycleLimit = 10 * instrCount + 100;

	logic clk;
	logic reset;
	logic instrValid;
	cpuPkg::instrWord instr;
	logic retireCredit;
	logic instrCredit;
	logic retireValid;
	cpuPkg::retireKind retireKind;
	cpuPkg::regIndex retireDest;
	cpuPkg::dataWord retireValue;

	integer seed;
	int cycles;
	int nextSend;
	int sendCredits;
	int creditsGranted;
	int retiredCount;
	cpuPkg::instrWord progWords [$];
	cpuPkg::dataWord modelRegs [32];
	cpuPkg::dataWord modelMem [memWords];
	cpuPkg::retireKind expKind [$];
	cpuPkg::regIndex expDest [$];
	cpuPkg::dataWord expValue [$];

	clockGen #(.halfPeriod(5), .resetCycles(5)) clocks (.clk, .reset);

	pipelinedCpu #(.queueDepth(queueDepth), .memWords(memWords)) DUT (
		.clk, .reset, .instrValid, .instr, .retireCredit,
		.instrCredit, .retireValid, .retireKind, .retireDest, .retireValue
	);

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display(">>> FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic checkKind(input cpuPkg::retireKind got, input cpuPkg::retireKind expected);
		if (got !== expected) begin
			abortRun($sformatf("FAILED at %0t: retireKind got %s expected %s",
				$time, got.name(), expected.name()));
		end
	endtask

	task automatic checkDest(input cpuPkg::regIndex got, input cpuPkg::regIndex expected);
		if (got !== expected) begin
			abortRun($sformatf("FAILED at %0t: retireDest got %0d expected %0d",
				$time, got, expected));
		end
	endtask

	task automatic checkValue(input cpuPkg::dataWord got, input cpuPkg::dataWord expected);
		if (got !== expected) begin
			abortRun($sformatf("FAILED at %0t: retireValue got %h expected %h",
				$time, got, expected));
		end
	endtask

	function automatic cpuPkg::dataWord signExtend(input logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	function automatic cpuPkg::instrWord rFormat(input cpuPkg::regIndex rs,
		input cpuPkg::regIndex rt, input cpuPkg::regIndex rd, input cpuPkg::funcCode func);
		return {cpuPkg::opRType, rs, rt, rd, 5'd0, func};
	endfunction

	function automatic cpuPkg::instrWord iFormat(input cpuPkg::opcode op,
		input cpuPkg::regIndex rs, input cpuPkg::regIndex rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic cpuPkg::regIndex randomReg();
		// Only r0 to r7 so that hazards come often
		return cpuPkg::regIndex'($random(seed) & 7);
	endfunction

	function automatic int memAddress(input cpuPkg::regIndex rs, input logic [15:0] imm);
		cpuPkg::dataWord sum;
		sum = modelRegs[rs] + signExtend(imm);
		return int'(sum % memWords);
	endfunction

	task automatic queueExpected(input cpuPkg::instrWord word, input cpuPkg::retireKind kind,
		input cpuPkg::regIndex dest, input cpuPkg::dataWord value);
		progWords.push_back(word);
		expKind.push_back(kind);
		expDest.push_back(dest);
		expValue.push_back(value);
		if (kind != cpuPkg::kindStore && dest != 5'd0) begin
			modelRegs[dest] = value;
		end
	endtask

	task automatic rTypeInstr(input cpuPkg::funcCode func, input cpuPkg::regIndex rs,
		input cpuPkg::regIndex rt, input cpuPkg::regIndex rd);
		cpuPkg::dataWord a;
		cpuPkg::dataWord b;
		cpuPkg::dataWord result;
		a = modelRegs[rs];
		b = modelRegs[rt];
		case (func)
			cpuPkg::funcSub: result = a - b;
			cpuPkg::funcSlt: result = (a < b) ? 32'd1 : 32'd0;
			default: result = a + b;
		endcase
		queueExpected(rFormat(rs, rt, rd, func), cpuPkg::kindAlu, rd, result);
	endtask

	task automatic immInstr(input cpuPkg::opcode op, input cpuPkg::regIndex rs,
		input cpuPkg::regIndex rt, input logic [15:0] imm);
		cpuPkg::dataWord result;
		result = (op == cpuPkg::opLi) ? signExtend(imm) : (modelRegs[rs] ^ signExtend(imm));
		queueExpected(iFormat(op, rs, rt, imm), cpuPkg::kindAlu, rt, result);
	endtask

	task automatic loadInstr(input cpuPkg::regIndex rs, input cpuPkg::regIndex rt,
		input logic [15:0] imm);
		queueExpected(iFormat(cpuPkg::opLw, rs, rt, imm), cpuPkg::kindLoad, rt,
			modelMem[memAddress(rs, imm)]);
	endtask

	task automatic storeInstr(input cpuPkg::regIndex rs, input cpuPkg::regIndex rt,
		input logic [15:0] imm);
		modelMem[memAddress(rs, imm)] = modelRegs[rt];
		queueExpected(iFormat(cpuPkg::opSw, rs, rt, imm), cpuPkg::kindStore, 5'd0,
			modelRegs[rt]);
	endtask

	task automatic buildProgram();
		int pick;
		cpuPkg::regIndex rs;
		cpuPkg::regIndex rt;
		cpuPkg::regIndex rd;
		logic [15:0] imm;
		for (int r = 0; r < 32; r++) begin
			modelRegs[r] = '0;
		end
		for (int a = 0; a < memWords; a++) begin
			immInstr(cpuPkg::opLi, 5'd0, 5'd1, 16'($random(seed)));
			storeInstr(5'd0, 5'd1, 16'(a));
		end
		for (int i = 0; i < randomCount; i++) begin
			pick = $random(seed) & 7;
			rs = randomReg();
			rt = randomReg();
			rd = randomReg();
			imm = 16'($random(seed));
			case (pick)
				0: rTypeInstr(cpuPkg::funcAdd, rs, rt, rd);
				1: rTypeInstr(cpuPkg::funcSub, rs, rt, rd);
				2: rTypeInstr(cpuPkg::funcSlt, rs, rt, rd);
				3: immInstr(cpuPkg::opXori, rs, rt, imm);
				4: immInstr(cpuPkg::opLi, 5'd0, rt, imm);
				5, 6: loadInstr(rs, rt, imm);
				default: storeInstr(rs, rt, imm);
			endcase
		end
	endtask

	task automatic sampleOutputs();
		if (instrCredit) begin
			sendCredits++;
		end
		if (sendCredits > queueDepth) begin
			abortRun("More input credits came back than the queue can hold");
		end
		if (retireValid) begin
			if (retiredCount >= creditsGranted) begin
				abortRun("A retire record was sent without a granted credit");
			end
			checkKind(retireKind, expKind.pop_front());
			checkDest(retireDest, expDest.pop_front());
			checkValue(retireValue, expValue.pop_front());
			retiredCount++;
		end
	endtask

	task automatic driveInputs();
		// Random gaps on both credit paths
		if (nextSend < instrCount && sendCredits > 0 && ($random(seed) & 3) != 0) begin
			instrValid = 1'b1;
			instr = progWords[nextSend];
			nextSend++;
			sendCredits--;
		end else begin
			instrValid = 1'b0;
		end
		if (creditsGranted < instrCount && ($random(seed) & 1) != 0) begin
			retireCredit = 1'b1;
			creditsGranted++;
		end else begin
			retireCredit = 1'b0;
		end
	endtask

	always @(posedge clk) begin
		if (reset) begin
			cycles <= 0;
		end else begin
			cycles <= cycles + 1;
			if (cycles >= cycleLimit) begin
				abortRun($sformatf("Timeout after %0d cycles with %0d of %0d instructions retired",
					cycles, retiredCount, instrCount));
			end
		end
	end

	initial begin
		seed = 32'h8e24;
		instrValid = 1'b0;
		instr = '0;
		retireCredit = 1'b0;
		nextSend = 0;
		sendCredits = queueDepth;
		creditsGranted = 0;
		retiredCount = 0;
		buildProgram();
		@(negedge reset);
		while (retiredCount < instrCount) begin
			@(posedge clk);
			#1;
			sampleOutputs();
			driveInputs();
		end
		instrValid = 1'b0;
		retireCredit = 1'b0;
		// Nothing may retire after the last instruction
		repeat (5) begin
			@(posedge clk);
			#1;
			if (retireValid) begin
				abortRun("A retire record came after the last instruction had retired");
			end
		end
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: pipelinedCpu.f
hdl/cpuPkg.sv
hdl/instrQueue.sv
hdl/registerFile.sv
hdl/issueStage.sv
hdl/aluPipe.sv
hdl/loadStorePipe.sv
hdl/retireStage.sv
hdl/pipelinedCpu.sv
bench/clockGen.sv
bench/pipelinedCpuTb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module pipelinedCpuTb \
		-f pipelinedCpu.f -o simv
	./obj_dir/simv | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log
